// ==== rtl/stim_params.svh ====
//####################
// Widths shared by RTL and testbench
// STIM_AW must equal log2 of STIM_DEPTH
// Control word is delay in bits 7..1 and continue in bit 0
//####################

`ifndef STIM_PARAMS_SVH
`define STIM_PARAMS_SVH

`define STIM_UW    32   // Payload bits
`define STIM_CW    8    // Control bits
`define STIM_DEPTH 64   // Memory words
`define STIM_AW    6    // Address bits

`endif

// ==== rtl/stim_mem_pkg.sv ====
//####################
// Memory side types
// Word layout is payload on top, then delay, then continue bit
//####################

`include "stim_params.svh"

package stim_mem_pkg;

   typedef struct packed {
      logic [`STIM_UW-1:0] payload;  // Data for the DUT
      logic [`STIM_CW-2:0] delay;    // Pause cycles after accept
      logic                cont;     // Clear marks end of sequence
   } stim_word_t;

   // Access kind on a requester bus
   typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;

   // Requester identity, host ranks first
   typedef enum logic {SRC_HOST, SRC_PLAYER} mem_src_t;

endpackage

// ==== rtl/stim_ctrl_pkg.sv ====
//####################
// Control side state encodings
//####################

package stim_ctrl_pkg;

   // Playback FSM
   typedef enum logic [2:0] {
      ST_IDLE,    // Waiting for go
      ST_FETCH,   // Read of next word in flight
      ST_ACTIVE,  // Payload offered to DUT
      ST_PAUSE,   // Counting down word delay
      ST_DONE     // End marker seen
   } player_state_t;

   // Host readback FSM
   typedef enum logic {
      HS_IDLE,
      HS_RD_WAIT  // Readback pending
   } host_state_t;

endpackage

// ==== rtl/stim_mem_if.sv ====
//####################
// One requester's path into the shared RAM
// Request fields hold until gnt, rdata valid one cycle after a granted read
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

interface stim_mem_if;

   // Requester side
   logic                        req;
   stim_mem_pkg::mem_op_t       op;
   logic [`STIM_AW-1:0]         addr;
   stim_mem_pkg::stim_word_t    wdata;

   // Memory side
   logic                        gnt;     // Combinational from both reqs
   logic                        rvalid;  // Read return strobe
   stim_mem_pkg::stim_word_t    rdata;

   modport requester (output req, op, addr, wdata,
                      input  gnt, rvalid, rdata);

   modport memory    (input  req, op, addr, wdata,
                      output gnt, rvalid, rdata);

endinterface

// ==== rtl/stim_shared_mem.sv ====
//####################
// Single port stimulus RAM shared by host and player
// Fixed priority, host always wins, one access per cycle
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

module stim_shared_mem (
   input logic          dut_clk,
   input logic          nreset,
   stim_mem_if.memory   host,
   stim_mem_if.memory   player
);

   stim_mem_pkg::stim_word_t  ram [`STIM_DEPTH];   // Storage, no reset
   stim_mem_pkg::stim_word_t  rdata_q;             // Read data register

   // Selected access for this cycle
   logic                      sel_valid;
   stim_mem_pkg::mem_src_t    sel_src;
   stim_mem_pkg::mem_op_t     sel_op;
   logic [`STIM_AW-1:0]       sel_addr;
   stim_mem_pkg::stim_word_t  sel_wdata;

   // Read return tracking
   logic                      rd_pend;
   stim_mem_pkg::mem_src_t    rd_src;

   //####################
   // Arbiter
   //####################
   assign host.gnt   = host.req;                 // Never stalled
   assign player.gnt = player.req & ~host.req;   // Loses to host
   assign sel_valid  = host.req | player.req;

   always_comb begin
      sel_src   = stim_mem_pkg::SRC_HOST;
      sel_op    = host.op;
      sel_addr  = host.addr;
      sel_wdata = host.wdata;
      if (!host.req) begin
         sel_src   = stim_mem_pkg::SRC_PLAYER;
         sel_op    = player.op;
         sel_addr  = player.addr;
         sel_wdata = player.wdata;
      end
   end

   //####################
   // RAM port
   //####################
   always_ff @(posedge dut_clk) begin
      if (sel_valid) begin
         if (sel_op == stim_mem_pkg::MEM_WRITE)
            ram[sel_addr] <= sel_wdata;   // Stored at grant edge
         else
            rdata_q <= ram[sel_addr];
      end
   end

   // Remember who owns the read in flight
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         rd_pend <= 1'b0;
         rd_src  <= stim_mem_pkg::SRC_HOST;
      end else begin
         rd_pend <= sel_valid & (sel_op == stim_mem_pkg::MEM_READ);
         rd_src  <= sel_src;
      end
   end

   assign host.rvalid   = rd_pend & (rd_src == stim_mem_pkg::SRC_HOST);
   assign player.rvalid = rd_pend & (rd_src == stim_mem_pkg::SRC_PLAYER);
   assign host.rdata    = rdata_q;   // Shared return bus
   assign player.rdata  = rdata_q;

endmodule

// ==== rtl/stim_host_port.sv ====
//####################
// Host loading and readback
// Write address only moves forward, cleared by reset
// Readback during playback is not supported
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

module stim_host_port (
   input  logic                          dut_clk,
   input  logic                          nreset,
   input  logic                          load,
   input  logic                          ext_valid,
   input  logic [`STIM_UW+`STIM_CW-1:0]  ext_packet,
   input  logic                          ext_rd,
   input  logic [`STIM_AW-1:0]           ext_rd_addr,
   output logic                          ext_rd_valid,
   output logic [`STIM_UW+`STIM_CW-1:0]  ext_rd_data,
   stim_mem_if.requester                 mem
);

   stim_ctrl_pkg::host_state_t  state;
   logic [`STIM_AW-1:0]         wr_addr;
   logic [`STIM_AW-1:0]         rd_addr_q;   // Latched readback address
   logic                        rd_sent;     // Read granted, awaiting data
   logic                        wr_now;
   stim_mem_pkg::stim_word_t    rd_word_q;

   assign wr_now = load & ext_valid;   // Write strobe

   // Writes take the bus ahead of a pending read
   assign mem.req   = wr_now | ((state == stim_ctrl_pkg::HS_RD_WAIT) & ~rd_sent);
   assign mem.op    = wr_now ? stim_mem_pkg::MEM_WRITE : stim_mem_pkg::MEM_READ;
   assign mem.addr  = wr_now ? wr_addr : rd_addr_q;
   assign mem.wdata = ext_packet;

   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         state        <= stim_ctrl_pkg::HS_IDLE;
         wr_addr      <= '0;
         rd_addr_q    <= '0;
         rd_sent      <= 1'b0;
         ext_rd_valid <= 1'b0;
      end else begin
         ext_rd_valid <= 1'b0;
         if (wr_now & mem.gnt)
            wr_addr <= wr_addr + 1'b1;   // Next sequential slot
         case (state)
            stim_ctrl_pkg::HS_IDLE: begin
               if (ext_rd) begin
                  rd_addr_q <= ext_rd_addr;
                  rd_sent   <= 1'b0;
                  state     <= stim_ctrl_pkg::HS_RD_WAIT;
               end
            end
            default: begin   // HS_RD_WAIT, new ext_rd ignored here
               if (!wr_now & mem.gnt)
                  rd_sent <= 1'b1;
               if (mem.rvalid) begin
                  ext_rd_valid <= 1'b1;   // One cycle pulse
                  state        <= stim_ctrl_pkg::HS_IDLE;
               end
            end
         endcase
      end
   end

   // Returned word, payload only so no reset
   always_ff @(posedge dut_clk)
      if (mem.rvalid) rd_word_q <= mem.rdata;

   assign ext_rd_data = rd_word_q;

endmodule

// ==== rtl/stim_player.sv ====
//####################
// Playback engine
// go is asynchronous and passes two flops
// Runs once per reset, then holds stim_done
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

module stim_player (
   input  logic                 dut_clk,
   input  logic                 nreset,
   input  logic                 go,
   input  logic                 dut_ready,
   output logic                 stim_valid,
   output logic [`STIM_UW-1:0]  stim_packet,
   output logic                 stim_done,
   stim_mem_if.requester        mem
);

   stim_ctrl_pkg::player_state_t  state;
   logic [1:0]                    go_sync;     // Synchronizer flops
   logic                          start;
   logic [`STIM_AW-1:0]           rd_addr;     // Next word to fetch
   logic [`STIM_CW-2:0]           delay_cnt;   // Pause down-counter
   logic                          fetch_sent;  // Read granted
   logic                          beat;
   stim_mem_pkg::stim_word_t      word_q;      // Word on offer

   //####################
   // go synchronizer
   //####################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset)
         go_sync <= 2'b00;
      else
         go_sync <= {go_sync[0], go};
   end

   assign start = go_sync[1];

   // Read-only requester
   assign mem.req   = (state == stim_ctrl_pkg::ST_FETCH) & ~fetch_sent;
   assign mem.op    = stim_mem_pkg::MEM_READ;
   assign mem.addr  = rd_addr;
   assign mem.wdata = '0;

   // DUT side
   assign stim_valid  = (state == stim_ctrl_pkg::ST_ACTIVE);
   assign stim_done   = (state == stim_ctrl_pkg::ST_DONE);
   assign stim_packet = word_q.payload;   // Holds while not accepted
   assign beat        = stim_valid & dut_ready;

   //####################
   // Playback FSM
   //####################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         state      <= stim_ctrl_pkg::ST_IDLE;
         rd_addr    <= '0;
         delay_cnt  <= '0;
         fetch_sent <= 1'b0;
      end else begin
         case (state)
            stim_ctrl_pkg::ST_IDLE: begin
               if (start) begin
                  fetch_sent <= 1'b0;
                  state      <= stim_ctrl_pkg::ST_FETCH;
               end
            end
            stim_ctrl_pkg::ST_FETCH: begin
               if (mem.req & mem.gnt)
                  fetch_sent <= 1'b1;   // Drop req, wait for data
               if (mem.rvalid) begin
                  fetch_sent <= 1'b0;
                  if (mem.rdata.cont)
                     state <= stim_ctrl_pkg::ST_ACTIVE;
                  else
                     state <= stim_ctrl_pkg::ST_DONE;   // End marker, never driven
               end
            end
            stim_ctrl_pkg::ST_ACTIVE: begin
               if (beat) begin
                  rd_addr   <= rd_addr + 1'b1;
                  delay_cnt <= word_q.delay;
                  if (word_q.delay == '0)
                     state <= stim_ctrl_pkg::ST_FETCH;   // No pause
                  else
                     state <= stim_ctrl_pkg::ST_PAUSE;
               end
            end
            stim_ctrl_pkg::ST_PAUSE: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == 1)
                  state <= stim_ctrl_pkg::ST_FETCH;   // Last pause cycle
            end
            default: state <= stim_ctrl_pkg::ST_DONE;   // Sticky until reset
         endcase
      end
   end

   // Capture fetched word
   always_ff @(posedge dut_clk)
      if (mem.rvalid) word_q <= mem.rdata;

endmodule

// ==== rtl/stim_top.sv ====
//####################
// Stimulus engine top
// Host writes during playback are not supported
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

module stim_top (
   input  logic                          dut_clk,
   input  logic                          nreset,
   input  logic                          load,
   input  logic                          go,
   input  logic                          ext_valid,
   input  logic [`STIM_UW+`STIM_CW-1:0]  ext_packet,
   input  logic                          ext_rd,
   input  logic [`STIM_AW-1:0]           ext_rd_addr,
   output logic                          ext_rd_valid,
   output logic [`STIM_UW+`STIM_CW-1:0]  ext_rd_data,
   input  logic                          dut_ready,
   output logic                          stim_valid,
   output logic [`STIM_UW-1:0]           stim_packet,
   output logic                          stim_done
);

   stim_mem_if host_bus ();     // Host to RAM
   stim_mem_if player_bus ();   // Player to RAM

   stim_host_port host_port_i (
      .dut_clk      (dut_clk),
      .nreset       (nreset),
      .load         (load),
      .ext_valid    (ext_valid),
      .ext_packet   (ext_packet),
      .ext_rd       (ext_rd),
      .ext_rd_addr  (ext_rd_addr),
      .ext_rd_valid (ext_rd_valid),
      .ext_rd_data  (ext_rd_data),
      .mem          (host_bus.requester)
   );

   stim_player player_i (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .go          (go),
      .dut_ready   (dut_ready),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done),
      .mem         (player_bus.requester)
   );

   stim_shared_mem mem_i (
      .dut_clk (dut_clk),
      .nreset  (nreset),
      .host    (host_bus.memory),
      .player  (player_bus.memory)
   );

endmodule

// ==== tests/stim_tb_table.svh ====
//####################
// Playback table, included inside the testbench module
// Columns are payload, delay, continue bit; sized for the default widths
// Last entry is the end marker and is never driven
//####################

`ifndef STIM_TB_TABLE_SVH
`define STIM_TB_TABLE_SVH

localparam int table_len = 8;   // Entries including end marker

// payload         delay  cont
localparam stim_mem_pkg::stim_word_t stim_table [table_len] = '{
   {32'hA5A5_0001, 7'd3, 1'b1},
   {32'h1234_5678, 7'd0, 1'b1},
   {32'hDEAD_BEEF, 7'd5, 1'b1},
   {32'h0F0F_00F0, 7'd1, 1'b1},
   {32'hCAFE_0042, 7'd0, 1'b1},
   {32'h8000_0007, 7'd4, 1'b1},
   {32'h0000_FFFF, 7'd2, 1'b1},
   {32'h7777_7777, 7'd1, 1'b0}   // End marker
};

`endif

// ==== tests/stim_tb.sv ====
//####################
// Testbench for the stimulus engine
// Loads the table, reads it back, plays it with random dut_ready
//####################

`timescale 1ns/100ps
`include "stim_params.svh"

module stim_tb;

   `include "stim_tb_table.svh"

   logic                          dut_clk, nreset, load, go, ext_valid, ext_rd, dut_ready;
   logic [`STIM_UW+`STIM_CW-1:0]  ext_packet, ext_rd_data;
   logic [`STIM_AW-1:0]           ext_rd_addr;
   logic                          ext_rd_valid, stim_valid, stim_done;
   logic [`STIM_UW-1:0]           stim_packet, held_packet;
   logic                          held;          // Offer not taken last cycle
   integer                        seed;
   int                            cyc, beats, gap, last_delay, wait_cnt;
   bit                            in_gap;

   stim_top dut_i (.*);

   always #4 dut_clk = ~dut_clk;   // 8 ns period

   // Step to 1 ns after the next rising edge
   task automatic next_cycle();
      @(posedge dut_clk);
      #1;
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   initial begin
      seed = 88;
      {dut_clk, nreset, load, go, ext_valid, ext_rd, dut_ready} = '0;
      ext_packet  = '0;
      ext_rd_addr = '0;
      repeat (2) @(posedge dut_clk);
      #1 nreset = 1'b1;
      check_value("stim_valid", 64'(stim_valid), 64'd0);
      check_value("stim_done", 64'(stim_done), 64'd0);
      check_value("ext_rd_valid", 64'(ext_rd_valid), 64'd0);

      //####################
      // Load and readback
      //####################
      for (int i = 0; i < table_len; i++) begin
         next_cycle();
         load       = 1'b1;
         ext_valid  = 1'b1;
         ext_packet = stim_table[i];
      end
      next_cycle();
      {load, ext_valid} = 2'b00;
      for (int i = 0; i < table_len; i++) begin
         next_cycle();
         ext_rd      = 1'b1;
         ext_rd_addr = i[`STIM_AW-1:0];
         next_cycle();
         ext_rd   = 1'b0;
         wait_cnt = 0;
         while (!ext_rd_valid && wait_cnt < 20) begin
            next_cycle();
            wait_cnt++;
         end
         if (!ext_rd_valid)
            report_failure($sformatf("Readback of address %0d never returned", i));
         check_value("ext_rd_data", 64'(ext_rd_data), 64'(stim_table[i]));
      end

      //####################
      // Playback
      //####################
      next_cycle();
      go         = 1'b1;
      cyc        = 0;
      beats      = 0;
      gap        = 0;
      last_delay = 0;
      held       = 1'b0;
      in_gap     = 1'b0;
      while (!stim_done && cyc < 2000) begin
         next_cycle();
         cyc++;
         if (held) begin   // Back-pressure must freeze the offer
            check_value("stim_valid", 64'(stim_valid), 64'd1);
            check_value("stim_packet", 64'(stim_packet), 64'(held_packet));
         end
         if (stim_valid && in_gap) begin
            if (gap < last_delay + 2)
               report_failure($sformatf("Pause of %0d cycles is shorter than delay %0d plus 2",
                                        gap, last_delay));
            in_gap = 1'b0;
         end else if (in_gap) begin
            gap++;   // Still paused
         end
         dut_ready = (($random(seed) & 3) != 0);   // Ready about 3 of 4 cycles
         if (beats == 0 && !held)
            dut_ready = 1'b0;   // First offer stalls at least once
         held        = stim_valid & ~dut_ready;
         held_packet = stim_packet;
         if (stim_valid && dut_ready) begin   // Beat at the next edge
            if (beats >= table_len - 1)
               report_failure("A beat was seen after the end marker");
            check_value("stim_packet", 64'(stim_packet), 64'(stim_table[beats].payload));
            last_delay = int'(stim_table[beats].delay);
            beats++;
            gap    = 0;
            in_gap = 1'b1;
         end
      end
      if (!stim_done)
         report_failure("stim_done never rose during playback");
      check_value("beat_count", 64'(beats), 64'(table_len - 1));

      dut_ready = 1'b0;
      repeat (20) begin   // Nothing more may be offered
         next_cycle();
         check_value("stim_valid", 64'(stim_valid), 64'd0);
         check_value("stim_done", 64'(stim_done), 64'd1);
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+rtl
+incdir+tests
rtl/stim_mem_pkg.sv
rtl/stim_ctrl_pkg.sv
rtl/stim_mem_if.sv
rtl/stim_shared_mem.sv
rtl/stim_host_port.sv
rtl/stim_player.sv
rtl/stim_top.sv
tests/stim_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is nonzero when the simulation stops on an error

cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module stim_tb -f sources.f -o stim_sim &&
./obj_dir/stim_sim ||
{ echo "Simulation build or run failed"; exit 1; }
